//--- hw/afifo.sv
`timescale 1ns/1ps

module afifo (
    input  logic             rst_,

    input  logic             w_clk,
    input  logic             w_trigger,         // Write request
    input  afifo_pkg::word_t w_data,
    output logic             w_ready,           // Not full

    input  logic             r_clk,
    input  logic             r_trigger,         // Read request
    output afifo_pkg::word_t r_data,
    output logic             r_ready            // Not empty
);

    localparam int AW = afifo_pkg::ADDR_W;

    afifo_pkg::ptr_t w_bptr;                    // Write pointer, binary
    afifo_pkg::ptr_t w_gptr;                    // Write pointer, Gray
    afifo_pkg::ptr_t w_bptr_next;
    afifo_pkg::ptr_t w_gptr_next;
    afifo_pkg::ptr_t w_rgptr_meta;              // Read pointer, first sync stage
    afifo_pkg::ptr_t w_rgptr;                   // Read pointer seen by writer
    logic            w_full;

    afifo_pkg::ptr_t r_bptr;
    afifo_pkg::ptr_t r_gptr;
    afifo_pkg::ptr_t r_bptr_next;
    afifo_pkg::ptr_t r_gptr_next;
    afifo_pkg::ptr_t r_wgptr_meta;
    afifo_pkg::ptr_t r_wgptr;                   // Write pointer seen by reader
    logic            r_not_empty;

    logic            w_push;
    logic            r_pop;

    // ========================================================================
    // Write side
    // ========================================================================
    assign w_push      = w_trigger && w_ready;
    assign w_bptr_next = w_push ? w_bptr + 1'b1 : w_bptr;
    assign w_gptr_next = (w_bptr_next >> 1) ^ w_bptr_next;

    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            w_bptr       <= '0;
            w_gptr       <= '0;
            w_rgptr_meta <= '0;
            w_rgptr      <= '0;
            w_full       <= 1'b0;
        end else begin
            w_bptr       <= w_bptr_next;
            w_gptr       <= w_gptr_next;
            w_rgptr_meta <= r_gptr;                 // Crosses from r_clk
            w_rgptr      <= w_rgptr_meta;
            // Full when writer is one lap ahead of the reader
            w_full       <= (w_gptr_next == {~w_rgptr[AW:AW-1], w_rgptr[AW-2:0]});
        end
    end

    assign w_ready = !w_full;

    // ========================================================================
    // Read side
    // ========================================================================
    assign r_pop       = r_trigger && r_ready;
    assign r_bptr_next = r_pop ? r_bptr + 1'b1 : r_bptr;
    assign r_gptr_next = (r_bptr_next >> 1) ^ r_bptr_next;

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            r_bptr       <= '0;
            r_gptr       <= '0;
            r_wgptr_meta <= '0;
            r_wgptr      <= '0;
            r_not_empty  <= 1'b0;
        end else begin
            r_bptr       <= r_bptr_next;
            r_gptr       <= r_gptr_next;
            r_wgptr_meta <= w_gptr;                 // Crosses from w_clk
            r_wgptr      <= r_wgptr_meta;
            r_not_empty  <= (r_gptr_next != r_wgptr);
        end
    end

    assign r_ready = r_not_empty;

    // ========================================================================
    // Storage
    // ========================================================================
    afifo_ram i_afifo_ram (
        .w_clk  (w_clk),
        .we     (w_push),
        .w_addr (w_bptr[AW-1:0]),
        .w_data (w_data),
        .r_clk  (r_clk),
        .r_addr (r_bptr_next[AW-1:0]),      // Next address keeps head on r_data
        .r_data (r_data)
    );

endmodule

//--- hw/afifo_pkg.sv
package afifo_pkg;

    // ========================================================================
    // Widths and depth
    // ========================================================================
    localparam int DATA_W = 16;
    localparam int ADDR_W = 8;
    localparam int DEPTH  = 1 << ADDR_W;                // 256 words

    localparam logic [7:0] LFSR_SEED = 8'h5a;           // Payload LFSR start value

    typedef logic [DATA_W-1:0] word_t;                  // {seq, payload}
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ADDR_W:0]   ptr_t;                   // Extra bit for wrap
    typedef logic [7:0]        seq_t;
    typedef logic [15:0]       count_t;

    typedef enum logic {
        SRC_IDLE,
        SRC_SEND
    } src_state_t;

    // Fibonacci LFSR, taps 7 5 4 3, shift left with feedback into bit 0
    function automatic seq_t lfsr_next(input seq_t s);
        logic fb;
        fb = s[7] ^ s[5] ^ s[4] ^ s[3];
        return {s[6:0], fb};
    endfunction

endpackage

//--- hw/afifo_ram.sv
`timescale 1ns/1ps

module afifo_ram (
    input  logic            w_clk,
    input  logic            we,
    input  afifo_pkg::addr_t w_addr,
    input  afifo_pkg::word_t w_data,

    input  logic            r_clk,
    input  afifo_pkg::addr_t r_addr,
    output afifo_pkg::word_t r_data
);

    afifo_pkg::word_t mem [afifo_pkg::DEPTH];

    // Write port
    always_ff @(posedge w_clk) begin
        if (we) begin
            mem[w_addr] <= w_data;
        end
    end

    // Read port, registered every cycle with no enable
    // The FIFO feeds the next read address, so the head word
    // is already on r_data while the FIFO reports not empty
    always_ff @(posedge r_clk) begin
        r_data <= mem[r_addr];
    end

endmodule

//--- hw/frame_sink.sv
`timescale 1ns/1ps

module frame_sink (
    input  logic              r_clk,
    input  logic              rst_,
    input  logic              sink_en,          // Allows popping
    input  logic              r_ready,
    input  afifo_pkg::word_t  r_data,
    output logic              r_trigger,
    output afifo_pkg::count_t rx_count,
    output afifo_pkg::word_t  last_word,
    output logic              seq_error         // Sticky until reset
);

    afifo_pkg::seq_t  exp_seq;
    afifo_pkg::seq_t  exp_lfsr;
    afifo_pkg::word_t exp_word;
    logic             pop;
    logic             is_head;

    assign r_trigger = r_ready && sink_en;
    assign pop       = r_trigger;               // r_ready already included

    assign exp_word  = {exp_seq, exp_lfsr};
    assign is_head   = (r_data == {8'h00, afifo_pkg::LFSR_SEED});  // Word 0 of a burst

    // ========================================================================
    // Expectation and error tracking
    // ========================================================================
    // The producer restarts at each burst, so a burst head word
    // re-arms the check at word 1 of the new burst
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            exp_seq   <= '0;
            exp_lfsr  <= afifo_pkg::LFSR_SEED;
            rx_count  <= '0;
            seq_error <= 1'b0;
        end else if (pop) begin
            rx_count <= rx_count + 1'b1;
            if (is_head) begin
                exp_seq  <= 8'h01;
                exp_lfsr <= afifo_pkg::lfsr_next(afifo_pkg::LFSR_SEED);
            end else begin
                exp_seq  <= exp_seq + 1'b1;
                exp_lfsr <= afifo_pkg::lfsr_next(exp_lfsr);
                if (r_data != exp_word) begin
                    seq_error <= 1'b1;
                end
            end
        end
    end

    // Last popped word
    always_ff @(posedge r_clk) begin
        if (pop) begin
            last_word <= r_data;
        end
    end

endmodule

//--- hw/frame_source.sv
`timescale 1ns/1ps

module frame_source (
    input  logic              w_clk,
    input  logic              rst_,
    input  logic              start,            // One-cycle pulse
    input  afifo_pkg::count_t word_count,       // Sampled at start
    input  logic              w_ready,
    output logic              w_trigger,
    output afifo_pkg::word_t  w_data,
    output logic              busy
);

    afifo_pkg::src_state_t state;
    afifo_pkg::count_t     remaining;           // Words still to send
    afifo_pkg::seq_t       seq;
    afifo_pkg::seq_t       lfsr;
    logic                  accepted;

    assign accepted = w_trigger && w_ready;

    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            state     <= afifo_pkg::SRC_IDLE;
            remaining <= '0;
            seq       <= '0;
            lfsr      <= afifo_pkg::LFSR_SEED;
        end else begin
            case (state)
                afifo_pkg::SRC_IDLE: begin
                    if (start && word_count != '0) begin  // Empty burst ignored
                        state     <= afifo_pkg::SRC_SEND;
                        remaining <= word_count;
                        seq       <= '0;
                        lfsr      <= afifo_pkg::LFSR_SEED;
                    end
                end
                afifo_pkg::SRC_SEND: begin
                    // Word held until the FIFO takes it
                    if (accepted) begin
                        remaining <= remaining - 1'b1;
                        seq       <= seq + 1'b1;
                        lfsr      <= afifo_pkg::lfsr_next(lfsr);
                        if (remaining == afifo_pkg::count_t'(1)) begin
                            state <= afifo_pkg::SRC_IDLE;
                        end
                    end
                end
                default: state <= afifo_pkg::SRC_IDLE;
            endcase
        end
    end

    assign w_trigger = (state == afifo_pkg::SRC_SEND);
    assign w_data    = {seq, lfsr};
    assign busy      = (state == afifo_pkg::SRC_SEND);

endmodule

//--- hw/xfer_top.sv
`timescale 1ns/1ps

module xfer_top (
    input  logic              w_clk,
    input  logic              r_clk,
    input  logic              rst_,             // Shared by both domains

    input  logic              start,            // w_clk domain
    input  afifo_pkg::count_t word_count,
    output logic              busy,

    input  logic              sink_en,          // r_clk domain
    output afifo_pkg::count_t rx_count,
    output afifo_pkg::word_t  last_word,
    output logic              seq_error
);

    // ========================================================================
    // Internal FIFO handshakes
    // ========================================================================
    logic             w_trigger;
    logic             w_ready;
    afifo_pkg::word_t w_data;
    logic             r_trigger;
    logic             r_ready;
    afifo_pkg::word_t r_data;

    frame_source i_frame_source (
        .w_clk      (w_clk),
        .rst_       (rst_),
        .start      (start),
        .word_count (word_count),
        .w_ready    (w_ready),
        .w_trigger  (w_trigger),
        .w_data     (w_data),
        .busy       (busy)
    );

    afifo i_afifo (
        .rst_      (rst_),
        .w_clk     (w_clk),
        .w_trigger (w_trigger),
        .w_data    (w_data),
        .w_ready   (w_ready),
        .r_clk     (r_clk),
        .r_trigger (r_trigger),
        .r_data    (r_data),
        .r_ready   (r_ready)
    );

    frame_sink i_frame_sink (
        .r_clk     (r_clk),
        .rst_      (rst_),
        .sink_en   (sink_en),
        .r_ready   (r_ready),
        .r_data    (r_data),
        .r_trigger (r_trigger),
        .rx_count  (rx_count),
        .last_word (last_word),
        .seq_error (seq_error)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the FIFO transfer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
BIN=xfer_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module xfer_tb -f sim.f --Mdir "$BUILD_DIR" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Assertion errors are counted by the testbench instead of stopping the run
"./$BUILD_DIR/$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    echo "Simulation reported errors, see $LOG"
    exit 1
fi

exit 0

//--- sim.f
hw/afifo_pkg.sv
hw/afifo_ram.sv
hw/afifo.sv
hw/frame_source.sv
hw/frame_sink.sv
hw/xfer_top.sv
verification/xfer_chk.sv
verification/xfer_tb.sv

//--- verification/xfer_chk.sv
`timescale 1ns/1ps

module xfer_chk (
    input  logic             w_clk,
    input  logic             r_clk,
    input  logic             rst_,
    input  logic             busy,
    input  logic             seq_error,
    input  logic             w_trigger,
    input  logic             w_ready,
    input  afifo_pkg::word_t w_data,
    input  logic             r_trigger,
    input  logic             r_ready,
    input  afifo_pkg::ptr_t  w_bptr,
    input  afifo_pkg::ptr_t  r_bptr,
    input  afifo_pkg::ptr_t  w_rgptr         // Read pointer after the synchronizer
);

    int              fail_count = 0;         // Read by the testbench at the end
    afifo_pkg::ptr_t fill;

    assign fill = w_bptr - r_bptr;           // True occupancy

    // ========================================================================
    // Reset values
    // ========================================================================
    reset_read_a: assert property (@(posedge r_clk) !rst_ |-> (!r_ready && !seq_error))
        else begin
            fail_count++;
            $error("Read side not in reset state while rst_ is low");
        end

    reset_write_a: assert property (@(posedge w_clk) !rst_ |-> (!busy && w_ready))
        else begin
            fail_count++;
            $error("Write side not in reset state while rst_ is low");
        end

    // ========================================================================
    // Flow control and data integrity
    // ========================================================================
    full_stall_a: assert property (@(posedge w_clk) disable iff (!rst_)
        (fill == afifo_pkg::ptr_t'(afifo_pkg::DEPTH)) |-> !w_ready)
        else begin
            fail_count++;
            $error("w_ready high with all %0d words in the FIFO", afifo_pkg::DEPTH);
        end

    // Stalled producer keeps its word
    hold_word_a: assert property (@(posedge w_clk) disable iff (!rst_)
        (w_trigger && !w_ready) |=> $stable(w_data))
        else begin
            fail_count++;
            $error("Producer changed w_data during a stall");
        end

    no_seq_error_a: assert property (@(posedge r_clk) disable iff (!rst_) !seq_error)
        else begin
            fail_count++;
            $error("Sink reported a sequence or payload mismatch");
        end

    ready_fall_a: assert property (@(posedge r_clk) disable iff (!rst_)
        $fell(r_ready) |-> $past(r_trigger))
        else begin
            fail_count++;
            $error("r_ready fell without a pop in the previous cycle");
        end

    // Space only appears once a moved read pointer has crossed over
    ready_rise_a: assert property (@(posedge w_clk) disable iff (!rst_)
        $rose(w_ready) |-> ($past(w_rgptr) != $past(w_rgptr, 2)))
        else begin
            fail_count++;
            $error("w_ready rose with no synchronized read");
        end

endmodule

bind xfer_top xfer_chk i_xfer_chk (
    .w_clk     (w_clk),
    .r_clk     (r_clk),
    .rst_      (rst_),
    .busy      (busy),
    .seq_error (seq_error),
    .w_trigger (w_trigger),
    .w_ready   (w_ready),
    .w_data    (w_data),
    .r_trigger (r_trigger),
    .r_ready   (r_ready),
    .w_bptr    (i_afifo.w_bptr),
    .r_bptr    (i_afifo.r_bptr),
    .w_rgptr   (i_afifo.w_rgptr)
);

//--- verification/xfer_tb.sv
`timescale 1ns/1ps

module xfer_tb;

    logic              w_clk;
    logic              r_clk;
    logic              rst_;
    logic              start;
    afifo_pkg::count_t word_count;
    logic              sink_en;
    logic              busy;
    afifo_pkg::count_t rx_count;
    afifo_pkg::word_t  last_word;
    logic              seq_error;

    int                errors;
    int                chk_fails;
    integer            seed;

    xfer_top i_xfer_top (
        .w_clk      (w_clk),
        .r_clk      (r_clk),
        .rst_       (rst_),
        .start      (start),
        .word_count (word_count),
        .busy       (busy),
        .sink_en    (sink_en),
        .rx_count   (rx_count),
        .last_word  (last_word),
        .seq_error  (seq_error)
    );

    always #4 r_clk = ~r_clk;                   // 8 ns
    always #5 w_clk = ~w_clk;                   // 10 ns, unrelated to r_clk

    // ========================================================================
    // Reference model of the word stream
    // ========================================================================
    function automatic logic [7:0] lfsr_after(input int steps);
        logic [7:0] s;
        logic       fb;
        s = afifo_pkg::LFSR_SEED;
        for (int i = 0; i < steps; i++) begin
            fb = s[7] ^ s[5] ^ s[4] ^ s[3];
            s  = {s[6:0], fb};
        end
        return s;
    endfunction

    function automatic afifo_pkg::word_t expected_word(input int idx);
        return {idx[7:0], lfsr_after(idx)};    // Sequence wraps at 256
    endfunction

    // Inputs change 1 ns after the edge of their own clock
    task automatic r_tick();
        @(posedge r_clk);
        #1;
    endtask

    task automatic w_tick();
        @(posedge w_clk);
        #1;
    endtask

    task automatic set_sink(input logic en);
        r_tick();
        sink_en = en;
    endtask

    task automatic send_burst(input int n);
        w_tick();
        word_count = afifo_pkg::count_t'(n);
        start      = 1'b1;
        w_tick();
        start      = 1'b0;
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
        end
    endtask

    task automatic check_results(input string test_name, input int exp_count,
                                 input int last_idx);
        check_value({test_name, " rx_count"}, exp_count, rx_count);
        check_value({test_name, " last_word"}, expected_word(last_idx), last_word);
        check_value({test_name, " seq_error"}, 0, seq_error);
    endtask

    // ========================================================================
    // Waits, each bounded
    // ========================================================================
    task automatic wait_busy_low(input string test_name);
        int n;
        n = 0;
        while (busy && n < 2000) begin
            w_tick();
            n++;
        end
        if (busy) begin
            errors++;
            $display("Timeout in %s: producer never finished its burst", test_name);
        end
    endtask

    task automatic wait_fifo_full(input string test_name);
        int n;
        n = 0;
        while (i_xfer_top.w_ready && n < 1000) begin
            w_tick();
            n++;
        end
        if (i_xfer_top.w_ready) begin
            errors++;
            $display("Timeout in %s: FIFO never filled up", test_name);
        end
    endtask

    // Done once rx_count has been quiet for 16 read cycles
    task automatic wait_rx_settle(input string test_name);
        int                n;
        int                quiet;
        afifo_pkg::count_t prev;
        n     = 0;
        quiet = 0;
        prev  = rx_count;
        while (quiet < 16 && n < 4000) begin
            r_tick();
            n++;
            if (rx_count == prev) begin
                quiet++;
            end else begin
                quiet = 0;
                prev  = rx_count;
            end
        end
        if (quiet < 16) begin
            errors++;
            $display("Timeout in %s: received word count kept changing", test_name);
        end
    endtask

    task automatic toggle_sink_randomly(input int target);
        int guard;
        int hold;
        guard = 0;
        while (rx_count != target && guard < 8000) begin
            hold = ($random(seed) & 15) + 1;
            r_tick();
            sink_en = ~sink_en;
            repeat (hold) r_tick();
            guard = guard + hold + 1;
        end
        if (rx_count != target) begin
            errors++;
            $display("Timeout in random_stalls: %0d words never arrived", target);
        end
    endtask

    initial begin
        errors     = 0;
        seed       = 32'h9efc;
        w_clk      = 1'b0;
        r_clk      = 1'b0;
        rst_       = 1'b1;
        start      = 1'b0;
        word_count = '0;
        sink_en    = 1'b0;
        #1 rst_ = 1'b0;
        repeat (5) @(posedge r_clk);
        #1 rst_ = 1'b1;

        set_sink(1'b1);
        send_burst(10);
        wait_busy_low("short_burst");
        wait_rx_settle("short_burst");
        check_results("short_burst", 10, 9);

        // Sink held off until the producer stalls on a full FIFO
        set_sink(1'b0);
        send_burst(300);
        wait_fifo_full("back_pressure");
        check_value("back_pressure busy", 1, busy);
        set_sink(1'b1);
        wait_busy_low("back_pressure");
        wait_rx_settle("back_pressure");
        check_results("back_pressure", 310, 299);

        send_burst(200);
        toggle_sink_randomly(510);
        set_sink(1'b1);
        wait_busy_low("random_stalls");
        wait_rx_settle("random_stalls");
        check_results("random_stalls", 510, 199);

        chk_fails = i_xfer_top.i_xfer_chk.fail_count;
        $display("Errors: %0d testbench checks, %0d assertions", errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
